//--- rtl/up_macros.svh
`ifndef UP_MACROS_SVH
`define UP_MACROS_SVH

// Architecture widths.
`define UP_DATA_W 8
`define UP_ADDR_W 8

// Program occupies 0x00-0x7F, data from here up.
`define UP_DATA_BASE 8'h80

`endif

//--- rtl/upPkg.sv
package upPkg;

	typedef enum logic [3:0] {
		OP_HALT = 4'd0,
		OP_LDA  = 4'd1,
		OP_STA  = 4'd2,
		OP_ALU  = 4'd3,
		OP_JMP  = 4'd4
	} opcodeT;

	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4
	} aluFuncT;

	typedef enum logic [3:0] {
		ALWAYS  = 4'd0,
		IFZERO  = 4'd1,
		IFCARRY = 4'd2
	} jumpCondT;

	// Upper nibble is always the opcode.
	typedef struct packed {
		opcodeT  opcode;
		aluFuncT func;
	} aluViewT;

	typedef struct packed {
		opcodeT   opcode;
		jumpCondT cond;
	} jumpViewT;

	typedef union packed {
		aluViewT  alu;
		jumpViewT jump;
	} instrT;

	typedef struct packed {
		logic zero;
		logic carry;
	} flagsT;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		FETCH   = 2'd1,
		OPERAND = 2'd2,
		EXECUTE = 2'd3
	} stateT;

endpackage

//--- rtl/upMemory.sv
`include "up_macros.svh"

module upMemory (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic [`UP_ADDR_W-1:0] address,
	input  logic [`UP_DATA_W-1:0] writeData,
	input  logic                  we,
	output logic [`UP_DATA_W-1:0] readData
);

	localparam int Depth = 1 << `UP_ADDR_W;

	logic [`UP_DATA_W-1:0] mem [0:Depth-1];

	assign readData = mem[address]; // Combinational read.

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < Depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[address] <= writeData;
		end
	end

endmodule

//--- rtl/upAlu.sv
`include "up_macros.svh"

module upAlu (
	input  logic [`UP_DATA_W-1:0] a,
	input  logic [`UP_DATA_W-1:0] b,
	input  upPkg::aluFuncT        func,
	output logic [`UP_DATA_W-1:0] result,
	output upPkg::flagsT          flags
);

	// One extra bit holds carry out or borrow.
	logic [`UP_DATA_W:0] sum;
	logic [`UP_DATA_W:0] diff;
	logic                carryOut;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		result   = b; // Unknown function passes the operand.
		carryOut = 1'b0;
		case (func)
			upPkg::ADD: begin
				result   = sum[`UP_DATA_W-1:0];
				carryOut = sum[`UP_DATA_W];
			end
			upPkg::SUB: begin
				result   = diff[`UP_DATA_W-1:0];
				carryOut = diff[`UP_DATA_W]; // Borrow.
			end
			upPkg::AND: result = a & b;
			upPkg::OR:  result = a | b;
			upPkg::XOR: result = a ^ b;
			default: ;
		endcase
	end

	assign flags.zero  = (result == '0);
	assign flags.carry = carryOut;

endmodule

//--- rtl/upDatapath.sv
`include "up_macros.svh"

module upDatapath (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic [`UP_DATA_W-1:0] memData,
	input  logic [`UP_DATA_W-1:0] aluResult,
	input  upPkg::flagsT          aluFlags,
	input  logic                  memSel,
	input  logic                  irLoad,
	input  logic                  addrLoad,
	input  logic                  pcInc,
	input  logic                  pcLoad,
	input  logic                  accLoad,
	input  logic                  accSrc,
	input  logic                  flagsLoad,
	input  logic                  runStart,
	output logic [`UP_ADDR_W-1:0] memAddr,
	output upPkg::instrT          instr,
	output logic [`UP_DATA_W-1:0] acc,
	output upPkg::flagsT          flags
);

	logic [`UP_ADDR_W-1:0] pc;
	logic [`UP_ADDR_W-1:0] addrReg;
	upPkg::flagsT          flagsNext;

	assign memAddr = memSel ? addrReg : pc; // High selects the operand.

	// --------------------------------------------------
	// Program counter.
	// --------------------------------------------------
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
		end else if (runStart) begin
			pc <= '0;
		end else if (pcLoad) begin
			pc <= addrReg; // Taken jump.
		end else if (pcInc) begin
			pc <= pc + 1'b1;
		end
	end

	// --------------------------------------------------
	// Instruction and operand address.
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (irLoad) begin
			instr <= upPkg::instrT'(memData);
		end
		if (addrLoad) begin
			addrReg <= memData;
		end
	end

	// --------------------------------------------------
	// Accumulator and flags.
	// --------------------------------------------------
	always_comb begin
		if (accSrc) begin
			flagsNext = aluFlags;
		end else begin
			flagsNext.zero  = (memData == '0); // Load sets zero only.
			flagsNext.carry = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc   <= '0;
			flags <= '0;
		end else begin
			if (accLoad) begin
				acc <= accSrc ? aluResult : memData;
			end
			if (flagsLoad) begin
				flags <= flagsNext;
			end
		end
	end

endmodule

//--- rtl/upControl.sv
module upControl (
	input  logic         clk,
	input  logic         nRst,
	input  logic         run,
	input  upPkg::instrT instr,
	input  upPkg::flagsT flags,
	output logic         memSel,
	output logic         irLoad,
	output logic         addrLoad,
	output logic         pcInc,
	output logic         pcLoad,
	output logic         accLoad,
	output logic         accSrc,
	output logic         flagsLoad,
	output logic         runStart,
	output logic         memWe,
	output logic         busy
);

	upPkg::stateT state;
	upPkg::stateT stateNext;
	logic         jumpTaken;

	// --------------------------------------------------
	// Jump condition.
	// --------------------------------------------------
	always_comb begin
		case (instr.jump.cond)
			upPkg::ALWAYS:  jumpTaken = 1'b1;
			upPkg::IFZERO:  jumpTaken = flags.zero;
			upPkg::IFCARRY: jumpTaken = flags.carry;
			default:        jumpTaken = 1'b0; // Never taken.
		endcase
	end

	// --------------------------------------------------
	// Sequencer and decode.
	// --------------------------------------------------
	always_comb begin
		stateNext = state;
		memSel    = 1'b0;
		irLoad    = 1'b0;
		addrLoad  = 1'b0;
		pcInc     = 1'b0;
		pcLoad    = 1'b0;
		accLoad   = 1'b0;
		accSrc    = 1'b0;
		flagsLoad = 1'b0;
		runStart  = 1'b0;
		memWe     = 1'b0;

		case (state)
			upPkg::IDLE: begin
				if (run) begin
					runStart  = 1'b1;
					stateNext = upPkg::FETCH;
				end
			end

			upPkg::FETCH: begin
				irLoad    = 1'b1;
				pcInc     = 1'b1;
				stateNext = upPkg::OPERAND;
			end

			upPkg::OPERAND: begin
				addrLoad  = 1'b1;
				pcInc     = 1'b1;
				stateNext = upPkg::EXECUTE;
			end

			upPkg::EXECUTE: begin
				memSel    = 1'b1; // Memory sees the operand address.
				stateNext = upPkg::FETCH;
				case (instr.alu.opcode)
					upPkg::OP_LDA: begin
						accLoad   = 1'b1;
						flagsLoad = 1'b1;
					end
					upPkg::OP_STA: begin
						memWe = 1'b1;
					end
					upPkg::OP_ALU: begin
						accLoad   = 1'b1;
						accSrc    = 1'b1;
						flagsLoad = 1'b1;
					end
					upPkg::OP_JMP: begin
						pcLoad = jumpTaken;
					end
					default: begin
						stateNext = upPkg::IDLE; // Halt or unknown opcode.
					end
				endcase
			end

			default: stateNext = upPkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= upPkg::IDLE;
		end else begin
			state <= stateNext;
		end
	end

	assign busy = (state != upPkg::IDLE);

endmodule

//--- rtl/upCore.sv
`include "up_macros.svh"

module upCore (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic                  run,
	input  logic                  hostWe,
	input  logic [`UP_ADDR_W-1:0] hostAddr,
	input  logic [`UP_DATA_W-1:0] hostData,
	output logic                  busy,
	output logic [`UP_DATA_W-1:0] acc,
	output upPkg::flagsT          flags,
	output logic [`UP_DATA_W-1:0] memOut
);

	logic [`UP_ADDR_W-1:0] coreAddr;
	logic [`UP_ADDR_W-1:0] memAddress;
	logic [`UP_DATA_W-1:0] memWriteData;
	logic                  memWriteEn;
	logic [`UP_DATA_W-1:0] aluResult;
	upPkg::flagsT          aluFlags;
	upPkg::instrT          instr;

	logic memSel;
	logic irLoad;
	logic addrLoad;
	logic pcInc;
	logic pcLoad;
	logic accLoad;
	logic accSrc;
	logic flagsLoad;
	logic runStart;
	logic memWe;

	// Host owns the memory port while the core is idle.
	assign memAddress   = busy ? coreAddr : hostAddr;
	assign memWriteData = busy ? acc : hostData;
	assign memWriteEn   = busy ? memWe : hostWe;

	upMemory i_upMemory (
		.clk       (clk),
		.nRst      (nRst),
		.address   (memAddress),
		.writeData (memWriteData),
		.we        (memWriteEn),
		.readData  (memOut)
	);

	upAlu i_upAlu (
		.a      (acc),
		.b      (memOut),
		.func   (instr.alu.func),
		.result (aluResult),
		.flags  (aluFlags)
	);

	upDatapath i_upDatapath (
		.clk       (clk),
		.nRst      (nRst),
		.memData   (memOut),
		.aluResult (aluResult),
		.aluFlags  (aluFlags),
		.memSel    (memSel),
		.irLoad    (irLoad),
		.addrLoad  (addrLoad),
		.pcInc     (pcInc),
		.pcLoad    (pcLoad),
		.accLoad   (accLoad),
		.accSrc    (accSrc),
		.flagsLoad (flagsLoad),
		.runStart  (runStart),
		.memAddr   (coreAddr),
		.instr     (instr),
		.acc       (acc),
		.flags     (flags)
	);

	upControl i_upControl (
		.clk       (clk),
		.nRst      (nRst),
		.run       (run),
		.instr     (instr),
		.flags     (flags),
		.memSel    (memSel),
		.irLoad    (irLoad),
		.addrLoad  (addrLoad),
		.pcInc     (pcInc),
		.pcLoad    (pcLoad),
		.accLoad   (accLoad),
		.accSrc    (accSrc),
		.flagsLoad (flagsLoad),
		.runStart  (runStart),
		.memWe     (memWe),
		.busy      (busy)
	);

endmodule

//--- testbench/upCoreTb.sv
`include "up_macros.svh"

module upCoreTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumPrograms   = 20;
	localparam int TimeoutCycles = NumPrograms * (256 + 3 * 31 + 256 + 100);

	logic         clk;
	logic         nRst;
	logic         run;
	logic         hostWe;
	logic [7:0]   hostAddr;
	logic [7:0]   hostData;
	logic         busy;
	logic [7:0]   acc;
	upPkg::flagsT flags;
	logic [7:0]   memOut;

	integer     seed;
	int         cycleCount;
	logic [7:0] modelMem [0:255]; // Reference copy of the DUT memory.
	logic [7:0] modelAcc;
	logic       modelZero;
	logic       modelCarry;

	upCore i_upCore (
		.clk      (clk),
		.nRst     (nRst),
		.run      (run),
		.hostWe   (hostWe),
		.hostAddr (hostAddr),
		.hostData (hostData),
		.busy     (busy),
		.acc      (acc),
		.flags    (flags),
		.memOut   (memOut)
	);

	always #5 clk = ~clk;

	initial begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Simulation timed out after %0d cycles.", cycleCount);
		$display("tests failed");
		$fatal(1);
	end

	// --------------------------------------------------
	// Helpers.
	// --------------------------------------------------
	task automatic checkValue(input string name, input int actual, input int expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h",
				$time, name, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] randomWord();
		return $random(seed);
	endfunction

	task automatic hostWrite(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		hostWe   = 1'b1;
		hostAddr = addr;
		hostData = data;
	endtask

	// Reads one byte mid-cycle and compares it with the model.
	task automatic checkByte(input logic [7:0] addr);
		@(posedge clk);
		#1;
		hostWe   = 1'b0;
		hostAddr = addr;
		#4;
		checkValue($sformatf("memOut[%02h]", addr), 32'(memOut), 32'(modelMem[addr]));
	endtask

	// Random data everywhere, then the program from address 0.
	task automatic buildProgram(input int n);
		logic [31:0] r;
		int          pick;
		for (int a = 0; a < 256; a++) begin
			r = randomWord();
			modelMem[a] = r[7:0];
		end
		for (int i = 0; i < n - 1; i++) begin
			r = randomWord();
			modelMem[2 * i + 1] = `UP_DATA_BASE | {1'b0, r[14:8]};
			case (r[1:0])
				2'd0: modelMem[2 * i] = {upPkg::OP_LDA, r[7:4]};
				2'd1: modelMem[2 * i] = {upPkg::OP_STA, r[7:4]};
				2'd2: modelMem[2 * i] = {upPkg::OP_ALU, 1'b0, r[6:4]}; // Includes pass-through.
				default: begin
					modelMem[2 * i] = {upPkg::OP_JMP, 2'b00, r[5:4]};
					pick = i + 1 + int'(r[31:16] % 16'(n - 1 - i)); // Later instruction only.
					modelMem[2 * i + 1] = 8'(2 * pick);
				end
			endcase
		end
		r = randomWord();
		modelMem[2 * (n - 1)] = r[8] ? {4'h0, r[7:4]} : {4'hF, r[7:4]};
	endtask

	// --------------------------------------------------
	// Reference model.
	// --------------------------------------------------
	task automatic runModel(output int executed);
		logic [7:0] pc;
		logic [7:0] op;
		logic [7:0] b;
		logic [8:0] wide;
		logic       taken;
		logic       done;
		pc       = 8'd0;
		executed = 0;
		done     = 1'b0;
		while (!done) begin
			op = modelMem[pc];
			b  = modelMem[pc + 8'd1]; // Operand address.
			pc = pc + 8'd2;
			executed++;
			case (op[7:4])
				upPkg::OP_LDA: begin
					modelAcc   = modelMem[b];
					modelZero  = (modelAcc == 8'd0);
					modelCarry = 1'b0;
				end
				upPkg::OP_STA: modelMem[b] = modelAcc;
				upPkg::OP_ALU: begin
					case (op[3:0])
						upPkg::ADD: wide = {1'b0, modelAcc} + {1'b0, modelMem[b]};
						upPkg::SUB: wide = {modelAcc < modelMem[b], modelAcc - modelMem[b]};
						upPkg::AND: wide = {1'b0, modelAcc & modelMem[b]};
						upPkg::OR:  wide = {1'b0, modelAcc | modelMem[b]};
						upPkg::XOR: wide = {1'b0, modelAcc ^ modelMem[b]};
						default:    wide = {1'b0, modelMem[b]};
					endcase
					modelAcc   = wide[7:0];
					modelCarry = wide[8];
					modelZero  = (modelAcc == 8'd0);
				end
				upPkg::OP_JMP: begin
					case (op[3:0])
						upPkg::ALWAYS:  taken = 1'b1;
						upPkg::IFZERO:  taken = modelZero;
						upPkg::IFCARRY: taken = modelCarry;
						default:        taken = 1'b0;
					endcase
					if (taken) begin
						pc = b;
					end
				end
				default: done = 1'b1; // Halt.
			endcase
		end
	endtask

	// Pulses run and counts cycles until busy falls.
	task automatic runDut(output int cycles);
		logic [31:0] r;
		logic        done;
		@(posedge clk);
		#1;
		hostWe = 1'b0;
		run    = 1'b1;
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge clk);
			#1;
			cycles++;
			r    = randomWord();
			done = !busy;
			run      = busy & r[0] & r[1]; // Stray run while busy.
			hostWe   = busy & r[2];        // Host write while busy.
			hostAddr = r[15:8];
			hostData = r[23:16];
		end
	endtask

	// --------------------------------------------------
	// Main sequence.
	// --------------------------------------------------
	initial begin
		logic [31:0] r;
		int          n;
		int          executed;
		int          cycles;
		seed       = 84;
		clk        = 1'b0;
		nRst       = 1'b0;
		run        = 1'b0;
		hostWe     = 1'b0;
		hostAddr   = 8'd0;
		hostData   = 8'd0;
		modelAcc   = 8'd0;
		modelZero  = 1'b0;
		modelCarry = 1'b0;
		for (int a = 0; a < 256; a++) begin
			modelMem[a] = 8'd0;
		end
		repeat (10) @(posedge clk);
		#1;
		nRst = 1'b1;

		checkValue("busy", 32'(busy), 0);
		checkValue("acc", 32'(acc), 0);
		checkValue("flags", 32'(flags), 0);
		repeat (16) begin
			r = randomWord();
			checkByte(r[7:0]);
		end

		for (int p = 0; p < NumPrograms; p++) begin
			r = randomWord();
			n = 8 + int'(r[15:0] % 16'd23);
			buildProgram(n);
			for (int a = 0; a < 256; a++) begin
				hostWrite(8'(a), modelMem[a]);
			end
			repeat (8) begin
				r = randomWord();
				checkByte(r[7:0]);
			end
			runModel(executed);
			runDut(cycles);
			checkValue("run-to-idle cycles", cycles, 3 * executed + 1);
			checkValue("acc", 32'(acc), 32'(modelAcc));
			checkValue("flags", 32'(flags), 32'({modelZero, modelCarry}));
			for (int a = 0; a < 256; a++) begin
				checkByte(8'(a));
			end
		end

		$display("all tests passed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+rtl
rtl/upPkg.sv
rtl/upMemory.sv
rtl/upAlu.sv
rtl/upDatapath.sv
rtl/upControl.sv
rtl/upCore.sv
testbench/upCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= upCoreTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
